// ==== Makefile ====
# Verilator build and run for the forwarding engine testbench

VERILATOR ?= verilator
TOP       ?= tb_forward_data_generator
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== backtrack_lane_gate.sv ====
module backtrack_lane_gate (
    input  fwd_gen_pkg::packet_payload_t    head,
    input  logic                            empty,
    input  logic                            out_ready,
    input  logic [fwd_gen_pkg::NUM_LANES-1:0] lane_ready,
    output logic                            rd_en,
    output logic                            pop_valid
);

    logic lane_ok;

    // Readiness of the lane the head packet is routed to
    assign lane_ok = lane_ready[head.route.destination];

    // ----------------------------------------
    // Release the head packet
    // ----------------------------------------
    assign rd_en     = ~empty & out_ready & lane_ok;
    assign pop_valid = rd_en;

endmodule

// ==== forward_data_generator.sv ====
module forward_data_generator #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                              ap_clk,
    input  logic                              areset,
    input  fwd_gen_pkg::descriptor_t          descriptor_in,
    input  fwd_gen_pkg::gen_config_t          config_in,
    input  fwd_gen_pkg::mem_packet_t          packet_in,
    input  logic                              out_ready,
    input  logic [fwd_gen_pkg::NUM_LANES-1:0] lane_ready,
    output fwd_gen_pkg::mem_packet_t          packet_out,
    output logic                              in_prog_full,
    output logic                              done_out
);

    import fwd_gen_pkg::*;

    logic                 areset_generator;
    descriptor_t          descriptor_reg;
    gen_config_t          config_reg;
    mem_packet_t          packet_in_reg;
    logic                 out_ready_reg;
    logic [NUM_LANES-1:0] lane_ready_reg;

    packet_payload_t in_fifo_dout;
    logic            in_fifo_rd_en;
    logic            in_fifo_empty;
    logic            in_fifo_prog_full;
    packet_payload_t out_fifo_din;
    packet_payload_t out_fifo_dout;
    logic            out_fifo_wr_en;
    logic            out_fifo_rd_en;
    logic            out_fifo_empty;
    logic            out_fifo_prog_full;

    logic              forward_enable;
    logic [HOPS_W-1:0] hops_param;
    logic              done_int;
    logic              pop_valid;

    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // ----------------------------------------
    // Input registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_reg      <= '0;
            config_reg.valid    <= 1'b0;
            packet_in_reg.valid <= 1'b0;
            out_ready_reg       <= 1'b0;
            lane_ready_reg      <= '0;
        end else begin
            descriptor_reg      <= descriptor_in;
            config_reg.valid    <= config_in.valid;
            packet_in_reg.valid <= packet_in.valid;
            out_ready_reg       <= out_ready;
            lane_ready_reg      <= lane_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        config_reg.hops       <= config_in.hops;
        packet_in_reg.payload <= packet_in.payload;
    end

    // ----------------------------------------
    // Forwarding pipeline
    // ----------------------------------------
    sync_fifo #(
        .payload_t  (packet_payload_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH),
        .FWFT       (1'b0)
    ) u_in_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (packet_in_reg.payload),
        .wr_en           (packet_in_reg.valid),
        .rd_en           (in_fifo_rd_en),
        .dout            (in_fifo_dout),
        .empty           (in_fifo_empty),
        .full            (),
        .prog_full       (in_fifo_prog_full)
    );

    fwd_gen_control u_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .descriptor      (descriptor_reg),
        .gen_config      (config_reg),
        .out_prog_full   (out_fifo_prog_full),
        .forward_enable  (forward_enable),
        .hops_param      (hops_param),
        .done            (done_int)
    );

    hop_forward_stage u_hop_stage (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .in_empty        (in_fifo_empty),
        .in_data         (in_fifo_dout),
        .forward_enable  (forward_enable),
        .hops_param      (hops_param),
        .in_rd_en        (in_fifo_rd_en),
        .out_wr_en       (out_fifo_wr_en),
        .out_data        (out_fifo_din)
    );

    // Head must be visible to the lane gate before the pop
    sync_fifo #(
        .payload_t  (packet_payload_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH),
        .FWFT       (1'b1)
    ) u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (out_fifo_din),
        .wr_en           (out_fifo_wr_en),
        .rd_en           (out_fifo_rd_en),
        .dout            (out_fifo_dout),
        .empty           (out_fifo_empty),
        .full            (),
        .prog_full       (out_fifo_prog_full)
    );

    backtrack_lane_gate u_lane_gate (
        .head      (out_fifo_dout),
        .empty     (out_fifo_empty),
        .out_ready (out_ready_reg),
        .lane_ready(lane_ready_reg),
        .rd_en     (out_fifo_rd_en),
        .pop_valid (pop_valid)
    );

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            packet_out.valid <= 1'b0;
            in_prog_full     <= 1'b0;
            done_out         <= 1'b1;
        end else begin
            packet_out.valid <= pop_valid;
            in_prog_full     <= in_fifo_prog_full;
            done_out         <= done_int;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_out.payload <= out_fifo_dout;
    end

endmodule

// ==== fwd_gen_checker.sv ====
module fwd_gen_checker (
    input  logic                              ap_clk,
    input  logic                              areset,
    input  fwd_gen_pkg::gen_config_t          config_in,
    input  fwd_gen_pkg::mem_packet_t          packet_in,
    input  logic                              out_ready,
    input  logic [fwd_gen_pkg::NUM_LANES-1:0] lane_ready,
    input  fwd_gen_pkg::mem_packet_t          packet_out,
    input  logic                              in_prog_full,
    input  logic                              done_out,
    input  logic                              quiet,
    input  logic                              done_chk,
    input  logic                              exp_done,
    input  logic                              pfull_chk,
    input  logic                              exp_prog_full,
    input  logic                              test_end,
    input  int                                test_num,
    output int                                outstanding,
    output int                                check_count,
    output int                                error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import fwd_gen_pkg::*;

    // Packets accepted by the DUT, oldest first
    packet_payload_t      model_q[$];
    logic [HOPS_W-1:0]    model_hops;
    logic                 ready_d1;
    logic                 ready_d2;
    logic [NUM_LANES-1:0] lane_d1;
    logic [NUM_LANES-1:0] lane_d2;
    int                   test_checks;
    int                   test_errors;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic packet_payload_t hop_rule(input packet_payload_t p,
                                                 input logic [HOPS_W-1:0] h);
        packet_payload_t r;
        int              left;
        r = p;
        left = int'(p.route.hops) - int'(h);
        r.route.hops = (left < 0) ? '0 : HOPS_W'(left);
        return r;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1: return "reset and idle";
            2: return "run and forward";
            3: return "drop rule";
            4: return "lane gating and back-pressure";
            5: return "stop and restart";
            default: return "unnamed";
        endcase
    endfunction

    task automatic tally(input bit ok);
        check_count = check_count + 1;
        test_checks = test_checks + 1;
        if (!ok) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
        end
    endtask

    // ----------------------------------------
    // Scoreboard
    // ----------------------------------------
    always @(posedge ap_clk) begin : monitor
        packet_payload_t      expected;
        logic [LANE_ID_W-1:0] dest;
        // Readiness seen by the pop, two edges before packet_out shows it
        ready_d1 <= out_ready;
        ready_d2 <= ready_d1;
        lane_d1  <= lane_ready;
        lane_d2  <= lane_d1;
        if (areset) begin
            model_q.delete();
            model_hops  = '0;
            outstanding = 0;
            check_count = 0;
            error_count = 0;
            test_checks = 0;
            test_errors = 0;
        end else begin
            if (packet_out.valid && quiet) begin
                $display("A packet left the DUT at %0d ns while the engine was stopped", $time);
                tally(1'b0);
            end else if (packet_out.valid) begin
                // Zero-hop packets ahead of this one were dropped
                while (model_q.size() > 0 && model_q[0].route.hops == '0) begin
                    void'(model_q.pop_front());
                end
                if (model_q.size() == 0) begin
                    $display("A packet left the DUT at %0d ns but none was expected", $time);
                    tally(1'b0);
                end else begin
                    expected = hop_rule(model_q.pop_front(), model_hops);
                    outstanding = outstanding - 1;
                    if (packet_out.payload !== expected) begin
                        $display("error at %0d ns: packet_out.payload expected %h got %h",
                                 $time, expected, packet_out.payload);
                    end
                    tally(packet_out.payload === expected);
                    dest = packet_out.payload.route.destination;
                    if (lane_d2[dest] !== 1'b1) begin
                        $display("error at %0d ns: lane_ready[%0d] expected 1 got %b",
                                 $time, dest, lane_d2[dest]);
                    end
                    tally(lane_d2[dest] === 1'b1);
                    if (ready_d2 !== 1'b1) begin
                        $display("error at %0d ns: out_ready expected 1 got %b",
                                 $time, ready_d2);
                    end
                    tally(ready_d2 === 1'b1);
                end
            end
            if (config_in.valid) begin
                model_hops = config_in.hops;
            end
            if (packet_in.valid) begin
                model_q.push_back(packet_in.payload);
                if (packet_in.payload.route.hops != '0) begin
                    outstanding = outstanding + 1;
                end
            end
            if (done_chk) begin
                if (done_out !== exp_done) begin
                    $display("error at %0d ns: done_out expected %b got %b",
                             $time, exp_done, done_out);
                end
                tally(done_out === exp_done);
            end
            if (pfull_chk) begin
                if (in_prog_full !== exp_prog_full) begin
                    $display("error at %0d ns: in_prog_full expected %b got %b",
                             $time, exp_prog_full, in_prog_full);
                end
                tally(in_prog_full === exp_prog_full);
            end
            if (test_end) begin
                $display("test %0d %s: %0d checks, %0d errors",
                         test_num, test_name(test_num), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// ==== fwd_gen_control.sv ====
module fwd_gen_control (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  fwd_gen_pkg::descriptor_t       descriptor,
    input  fwd_gen_pkg::gen_config_t       gen_config,
    input  logic                           out_prog_full,
    output logic                           forward_enable,
    output logic [fwd_gen_pkg::HOPS_W-1:0] hops_param,
    output logic                           done
);

    import fwd_gen_pkg::*;

    gen_state_t current_state;
    gen_state_t next_state;
    logic       start_req;
    logic       stop_req;

    assign start_req = descriptor.valid & descriptor.start;
    assign stop_req  = descriptor.valid & descriptor.stop;

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= GEN_IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            GEN_IDLE: begin
                if (start_req) begin
                    next_state = GEN_WAIT_CONFIG;
                end
            end
            GEN_WAIT_CONFIG: begin
                if (gen_config.valid) begin
                    next_state = GEN_BUSY;
                end
            end
            GEN_BUSY: begin
                // Stop wins over a pause request
                if (stop_req) begin
                    next_state = GEN_IDLE;
                end else if (out_prog_full) begin
                    next_state = GEN_PAUSE;
                end
            end
            GEN_PAUSE: begin
                if (stop_req) begin
                    next_state = GEN_IDLE;
                end else if (!out_prog_full) begin
                    next_state = GEN_BUSY;
                end
            end
            default: begin
                next_state = GEN_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // Hop parameter capture
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if ((current_state == GEN_WAIT_CONFIG) && gen_config.valid) begin
            hops_param <= gen_config.hops;
        end
    end

    assign forward_enable = (current_state == GEN_BUSY);
    assign done           = (current_state == GEN_IDLE);

endmodule

// ==== fwd_gen_pkg.sv ====
package fwd_gen_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int HOPS_W    = 4;
    localparam int LANE_ID_W = 2;
    localparam int NUM_LANES = 2 ** LANE_ID_W;
    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;

    // ----------------------------------------
    // Packet types
    // ----------------------------------------
    typedef struct packed {
        logic [HOPS_W-1:0]    hops;
        logic [LANE_ID_W-1:0] source;
        logic [LANE_ID_W-1:0] destination;
    } route_t;

    typedef struct packed {
        route_t            route;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
    } packet_payload_t;

    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } mem_packet_t;

    // ----------------------------------------
    // Run control types
    // ----------------------------------------
    typedef struct packed {
        logic valid;
        logic start;
        logic stop;
    } descriptor_t;

    // Hop count applied to every forwarded packet of a run
    typedef struct packed {
        logic              valid;
        logic [HOPS_W-1:0] hops;
    } gen_config_t;

    typedef enum logic [1:0] {
        GEN_IDLE        = 2'd0,
        GEN_WAIT_CONFIG = 2'd1,
        GEN_BUSY        = 2'd2,
        GEN_PAUSE       = 2'd3
    } gen_state_t;

endpackage

// ==== hop_forward_stage.sv ====
module hop_forward_stage (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  logic                           in_empty,
    input  fwd_gen_pkg::packet_payload_t   in_data,
    input  logic                           forward_enable,
    input  logic [fwd_gen_pkg::HOPS_W-1:0] hops_param,
    output logic                           in_rd_en,
    output logic                           out_wr_en,
    output fwd_gen_pkg::packet_payload_t   out_data
);

    import fwd_gen_pkg::*;

    // Set while a popped packet is on its way out of the input FIFO
    logic              pending;
    logic [HOPS_W-1:0] hops_left;

    assign in_rd_en = ~in_empty & forward_enable & ~pending;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            pending <= 1'b0;
        end else begin
            pending <= in_rd_en;
        end
    end

    // Saturating subtract of the configured hops
    assign hops_left = (in_data.route.hops >= hops_param) ?
                       in_data.route.hops - hops_param : '0;

    always_comb begin
        out_data            = in_data;
        out_data.route.hops = hops_left;
    end

    // Packets arriving with no hops left are dropped here
    assign out_wr_en = pending & (in_data.route.hops != '0);

endmodule

// ==== sim.f ====
fwd_gen_pkg.sv
sync_fifo.sv
fwd_gen_control.sv
hop_forward_stage.sv
backtrack_lane_gate.sv
forward_data_generator.sv
fwd_gen_checker.sv
tb_forward_data_generator.sv

// ==== sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t   = logic [7:0],
    parameter int  FIFO_DEPTH  = 16,
    parameter int  PROG_THRESH = 8,
    parameter bit  FWFT        = 1'b0
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  payload_t din,
    input  logic     wr_en,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty,
    output logic     full,
    output logic     prog_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // Requests beyond the limits are ignored
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write & ~do_read) begin
                count <= count + 1'b1;
            end else if (do_read & ~do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Read port style
    generate
        if (FWFT) begin : g_fwft
            assign dout = mem[rd_ptr];
        end else begin : g_std
            always_ff @(posedge ap_clk) begin
                if (do_read) begin
                    dout <= mem[rd_ptr];
                end
            end
        end
    endgenerate

endmodule

// ==== tb_forward_data_generator.sv ====
module tb_forward_data_generator;

    timeunit 1ns;
    timeprecision 100ps;

    import fwd_gen_pkg::*;

    localparam int FIFO_DEPTH      = 16;
    localparam int PROG_THRESH     = 8;
    localparam int SEED            = 93750;
    localparam int RUN_PACKETS     = 16;
    localparam int DROP_PACKETS    = 24;
    localparam int BP_PACKETS      = 40;
    localparam int STOP_PACKETS    = 6;
    localparam int TOTAL_PACKETS   = PROG_THRESH + RUN_PACKETS + DROP_PACKETS +
                                     BP_PACKETS + STOP_PACKETS;
    localparam int WATCHDOG_CYCLES = TOTAL_PACKETS * 200 + 2000;

    logic                 ap_clk;
    logic                 areset;
    descriptor_t          descriptor_in;
    gen_config_t          config_in;
    mem_packet_t          packet_in;
    logic                 out_ready;
    logic [NUM_LANES-1:0] lane_ready;
    mem_packet_t          packet_out;
    logic                 in_prog_full;
    logic                 done_out;

    logic              quiet;
    logic              done_chk;
    logic              exp_done;
    logic              pfull_chk;
    logic              exp_prog_full;
    logic              test_end;
    int                test_num;
    int                outstanding;
    int                check_count;
    int                error_count;
    bit                random_bp;
    logic [HOPS_W-1:0] run_hops;

    forward_data_generator #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_forward_data_generator (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .descriptor_in(descriptor_in),
        .config_in    (config_in),
        .packet_in    (packet_in),
        .out_ready    (out_ready),
        .lane_ready   (lane_ready),
        .packet_out   (packet_out),
        .in_prog_full (in_prog_full),
        .done_out     (done_out)
    );

    fwd_gen_checker u_checker (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .config_in    (config_in),
        .packet_in    (packet_in),
        .out_ready    (out_ready),
        .lane_ready   (lane_ready),
        .packet_out   (packet_out),
        .in_prog_full (in_prog_full),
        .done_out     (done_out),
        .quiet        (quiet),
        .done_chk     (done_chk),
        .exp_done     (exp_done),
        .pfull_chk    (pfull_chk),
        .exp_prog_full(exp_prog_full),
        .test_end     (test_end),
        .test_num     (test_num),
        .outstanding  (outstanding),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // Consumer and lane readiness, random only in the back-pressure test
    initial begin
        out_ready  = 1'b1;
        lane_ready = '1;
        forever begin
            @(posedge ap_clk);
            #2;
            if (random_bp) begin
                out_ready  = ($urandom_range(0, 3) != 0);
                lane_ready = NUM_LANES'($urandom);
            end else begin
                out_ready  = 1'b1;
                lane_ready = '1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles with %0d packets still outstanding",
                 WATCHDOG_CYCLES, outstanding);
        $display("Checks failed");
        $finish;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge ap_clk);
        #2;
    endtask

    function automatic packet_payload_t random_packet(input int min_hops, input int max_hops);
        packet_payload_t p;
        p.route.hops        = HOPS_W'($urandom_range(min_hops, max_hops));
        p.route.source      = LANE_ID_W'($urandom);
        p.route.destination = LANE_ID_W'($urandom);
        p.address           = ADDR_W'($urandom);
        p.data              = $urandom;
        return p;
    endfunction

    // Holds off while the input FIFO reports nearly full
    task automatic push_packet(input packet_payload_t p);
        next_cycle();
        while (in_prog_full) begin
            packet_in.valid = 1'b0;
            next_cycle();
        end
        packet_in.payload = p;
        packet_in.valid   = 1'b1;
    endtask

    task automatic stop_pushing();
        next_cycle();
        packet_in.valid = 1'b0;
    endtask

    task automatic send_descriptor(input logic start, input logic stop);
        next_cycle();
        descriptor_in = '{valid: 1'b1, start: start, stop: stop};
        next_cycle();
        descriptor_in = '0;
    endtask

    task automatic start_run(input logic [HOPS_W-1:0] hops);
        send_descriptor(1'b1, 1'b0);
        repeat (3) next_cycle();
        config_in = '{valid: 1'b1, hops: hops};
        next_cycle();
        config_in.valid = 1'b0;
    endtask

    task automatic check_done(input logic expected);
        next_cycle();
        exp_done = expected;
        done_chk = 1'b1;
        next_cycle();
        done_chk = 1'b0;
    endtask

    task automatic check_prog_full(input logic expected);
        next_cycle();
        exp_prog_full = expected;
        pfull_chk     = 1'b1;
        next_cycle();
        pfull_chk     = 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            next_cycle();
        end
        repeat (5) next_cycle();
    endtask

    task automatic end_test();
        next_cycle();
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int wait_count;
        void'($urandom(SEED));
        areset        = 1'b1;
        descriptor_in = '0;
        config_in     = '0;
        packet_in     = '0;
        quiet         = 1'b1;
        done_chk      = 1'b0;
        exp_done      = 1'b0;
        pfull_chk     = 1'b0;
        exp_prog_full = 1'b0;
        test_end      = 1'b0;
        test_num      = 0;
        random_bp     = 1'b0;
        repeat (10) @(posedge ap_clk);
        #2;
        areset = 1'b0;
        repeat (3) next_cycle();

        test_num = 1;
        check_done(1'b1);
        check_prog_full(1'b0);
        for (int i = 0; i < PROG_THRESH - 1; i++) begin
            push_packet(random_packet(0, 15));
        end
        stop_pushing();
        repeat (5) next_cycle();
        // One packet below the threshold
        check_prog_full(1'b0);
        push_packet(random_packet(0, 15));
        stop_pushing();
        wait_count = 0;
        while (!in_prog_full && wait_count < 20) begin
            next_cycle();
            wait_count++;
        end
        check_prog_full(1'b1);
        repeat (20) next_cycle();
        end_test();

        test_num = 2;
        run_hops = HOPS_W'($urandom_range(0, 7));
        start_run(run_hops);
        quiet    = 1'b0;
        repeat (4) next_cycle();
        check_done(1'b0);
        for (int i = 0; i < RUN_PACKETS; i++) begin
            push_packet(random_packet(0, 15));
        end
        stop_pushing();
        wait_drain();
        end_test();

        test_num = 3;
        for (int i = 0; i < DROP_PACKETS; i++) begin
            if (i % 3 == 1) begin
                push_packet(random_packet(0, 0));
            end else begin
                push_packet(random_packet(1, 15));
            end
        end
        stop_pushing();
        wait_drain();
        end_test();

        test_num  = 4;
        random_bp = 1'b1;
        for (int i = 0; i < BP_PACKETS; i++) begin
            push_packet(random_packet(0, 15));
        end
        stop_pushing();
        wait_drain();
        random_bp = 1'b0;
        end_test();

        test_num = 5;
        send_descriptor(1'b0, 1'b1);
        quiet = 1'b1;
        repeat (4) next_cycle();
        check_done(1'b1);
        for (int i = 0; i < STOP_PACKETS; i++) begin
            push_packet(random_packet(1, 15));
        end
        stop_pushing();
        repeat (30) next_cycle();
        run_hops = HOPS_W'((int'(run_hops) + $urandom_range(1, 7)) % 8);
        start_run(run_hops);
        quiet    = 1'b0;
        wait_drain();
        end_test();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
